// ==== verilog/decoderPkg.sv ====
/*
 * Telemetry decoder shared definitions: register map, line code and
 * derandomizer codes, and the control word layout
 */
package decoderPkg;

    // Register byte addresses
    parameter int unsigned decCtrlAddr     = 'h000;
    parameter int unsigned decStatusAddr   = 'h004;
    parameter int unsigned decFifoDataAddr = 'h008;

    // Line code selection when Miller and biphase are off
    parameter logic [1:0] nrzL = 2'd0;
    parameter logic [1:0] nrzM = 2'd1;
    parameter logic [1:0] nrzS = 2'd2;

    // Derandomizer polynomials
    parameter logic [2:0] derandOff   = 3'd0;
    parameter logic [2:0] derandIrig15 = 3'd1; // Taps 14 and 15
    parameter logic [2:0] derandV17   = 3'd2; // Taps 14 and 17

    typedef struct packed {
        logic [14:0] unused;
        logic        clkPhaseHi;
        logic        derandHi;
        logic        inputSelect;
        logic        bypassFifo;
        logic        derandMid;
        logic [1:0]  mode;
        logic        millerEnable;
        logic        biphaseEnable;
        logic        iqSwap;
        logic        feherEnable;
        logic        demuxEnable;
        logic        derandLo;
        logic        dataInvert;
        logic        clkSelect;
        logic        clkPhaseLo;
        logic        fifoReset;
    } decCtrlFields_s;

    typedef union packed {
        logic [31:0]    raw;    // Bus view, byte lanes
        decCtrlFields_s fields; // Named settings
    } decCtrlWord_u;

endpackage

// ==== verilog/decoderRegs.sv ====
/*
 * Decoder control register, written per byte lane from the host bus
 * and read back as one word
 */
`timescale 1ns/10ps

module decoderRegs #(
    parameter int AddrBits = 13
) (
    input  logic                     busClk,
    input  logic                     arstN,
    input  logic                     cs,
    input  logic                     wr0,
    input  logic                     wr1,
    input  logic                     wr2,
    input  logic                     wr3,
    input  logic [AddrBits-1:0]      addr,
    input  logic [31:0]              dataIn,
    output decoderPkg::decCtrlWord_u ctrlWord,
    output logic [31:0]              ctrlRead
);

    decoderPkg::decCtrlWord_u nextWord;
    logic                     ctrlHit;

    assign ctrlHit = cs && (addr == AddrBits'(decoderPkg::decCtrlAddr));

    // Merge written lanes into the current word
    always_comb begin
        nextWord = ctrlWord;
        if (ctrlHit) begin
            if (wr0) begin
                nextWord.raw[7:0] = dataIn[7:0];
            end
            if (wr1) begin
                nextWord.raw[15:8] = dataIn[15:8];
            end
            if (wr2) begin
                nextWord.raw[23:16] = dataIn[23:16];
            end
            if (wr3) begin
                nextWord.raw[31:24] = dataIn[31:24];
            end
        end
        nextWord.fields.unused = '0; // Spare bits read as zero
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            ctrlWord <= '0;
        end else begin
            ctrlWord <= nextWord;
        end
    end

    assign ctrlRead = ctrlWord.raw; // Readback view

endmodule

// ==== verilog/bitDecoder.sv ====
/*
 * Bit decoder: selects and inverts half-bit symbols, decodes the line code,
 * derandomizes and packs bits MSB-first into bytes
 */
`timescale 1ns/10ps

module bitDecoder (
    input  logic       busClk,
    input  logic       arstN,
    input  logic       symA,
    input  logic       symB,
    input  logic       symValid,
    input  logic       fifoReset,
    input  logic       inputSelect,
    input  logic       dataInvert,
    input  logic [1:0] mode,
    input  logic       biphaseEnable,
    input  logic       millerEnable,
    input  logic [2:0] derandomize,
    output logic [7:0] byteData,
    output logic       byteValid
);

    logic        symSel;
    logic        halfPhase;  // 1 while waiting for the second half
    logic        firstHalf;
    logic        prevFirst;  // First half of the previous bit
    logic        lineBit;
    logic        tapXor;
    logic        outBit;
    logic [16:0] history;    // Received bits, newest in bit 0
    logic [6:0]  shiftReg;
    logic [2:0]  bitCount;
    logic        bitDone;

    assign symSel  = (inputSelect ? symB : symA) ^ dataInvert;
    assign bitDone = symValid && halfPhase && !fifoReset;

    always_comb begin
        if (millerEnable) begin
            lineBit = firstHalf ^ symSel; // Transition within the bit
        end else if (biphaseEnable) begin
            lineBit = firstHalf;
        end else begin
            case (mode)
                decoderPkg::nrzL: lineBit = firstHalf;
                decoderPkg::nrzM: lineBit = firstHalf ^ prevFirst;
                decoderPkg::nrzS: lineBit = ~(firstHalf ^ prevFirst);
                default:          lineBit = firstHalf;
            endcase
        end
    end

    // Self-synchronizing descrambler taps
    always_comb begin
        case (derandomize)
            decoderPkg::derandOff:    tapXor = 1'b0;
            decoderPkg::derandIrig15: tapXor = history[13] ^ history[14];
            decoderPkg::derandV17:    tapXor = history[13] ^ history[16];
            default:                  tapXor = 1'b0;
        endcase
    end

    assign outBit = lineBit ^ tapXor;

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            halfPhase <= 1'b0;
            firstHalf <= 1'b0;
            prevFirst <= 1'b0;
            history   <= '0;
            shiftReg  <= '0;
            bitCount  <= '0;
            byteValid <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            if (fifoReset) begin
                halfPhase <= 1'b0;
                firstHalf <= 1'b0;
                prevFirst <= 1'b0;
                history   <= '0;
                shiftReg  <= '0;
                bitCount  <= '0;
            end else if (symValid) begin
                if (!halfPhase) begin
                    firstHalf <= symSel;
                    halfPhase <= 1'b1;
                end else begin
                    halfPhase <= 1'b0;
                    prevFirst <= firstHalf;
                    history   <= {history[15:0], lineBit};
                    shiftReg  <= {shiftReg[5:0], outBit};
                    bitCount  <= bitCount + 3'd1;
                    if (bitCount == 3'd7) begin
                        byteValid <= 1'b1; // Eighth bit of the byte
                    end
                end
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (bitDone && (bitCount == 3'd7)) begin
            byteData <= {shiftReg, outBit};
        end
    end

endmodule

// ==== verilog/decoderFifo.sv ====
/*
 * Byte FIFO between the bit decoder and the bus, with sticky overflow,
 * software clear and a bypass mode that keeps only the newest byte
 */
`timescale 1ns/10ps

module decoderFifo #(
    parameter int FifoDepthLog2 = 4
) (
    input  logic                   busClk,
    input  logic                   arstN,
    input  logic                   fifoReset,
    input  logic                   bypassFifo,
    input  logic [7:0]             byteData,
    input  logic                   byteValid,
    input  logic                   pop,
    output logic [7:0]             fifoData,
    output logic [FifoDepthLog2:0] fifoCount,
    output logic                   fifoOverflow
);

    localparam int Depth = 1 << FifoDepthLog2;

    logic [7:0]               mem [Depth];
    logic [FifoDepthLog2-1:0] wrPtr;
    logic [FifoDepthLog2-1:0] rdPtr;
    logic [FifoDepthLog2-1:0] memAddr;
    logic                     doPop;
    logic                     doPush;
    logic                     full;

    assign full   = (fifoCount == (FifoDepthLog2 + 1)'(Depth));
    assign doPop  = pop && (fifoCount != '0) && !fifoReset;
    assign doPush = byteValid && !fifoReset && (bypassFifo || !full || doPop);
    assign memAddr = bypassFifo ? rdPtr : wrPtr; // Bypass overwrites the head

    always_ff @(posedge busClk) begin
        if (doPush) begin
            mem[memAddr] <= byteData;
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            fifoCount    <= '0;
            fifoOverflow <= 1'b0;
        end else if (fifoReset) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            fifoCount    <= '0;
            fifoOverflow <= 1'b0;
        end else if (bypassFifo && doPush) begin
            wrPtr     <= rdPtr + 1'b1;
            fifoCount <= (FifoDepthLog2 + 1)'(1); // Single entry
        end else begin
            if (byteValid && !doPush) begin
                fifoOverflow <= 1'b1; // Sticky until cleared
            end
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   fifoCount <= fifoCount + 1'b1;
                2'b01:   fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
        end
    end

    assign fifoData = mem[rdPtr];

endmodule

// ==== verilog/busReadPort.sv ====
/*
 * Host read side: register readback mux, FIFO status word and
 * byte pop on data reads
 */
`timescale 1ns/10ps

module busReadPort #(
    parameter int AddrBits      = 13,
    parameter int FifoDepthLog2 = 4
) (
    input  logic                   cs,
    input  logic                   rd,
    input  logic [AddrBits-1:0]    addr,
    input  logic [31:0]            ctrlRead,
    input  logic [7:0]             fifoData,
    input  logic [FifoDepthLog2:0] fifoCount,
    input  logic                   fifoOverflow,
    output logic [31:0]            dataOut,
    output logic                   pop
);

    logic [31:0] statusWord;
    logic        fifoEmpty;
    logic        dataHit;

    assign fifoEmpty = (fifoCount == '0);
    assign dataHit   = (addr == AddrBits'(decoderPkg::decFifoDataAddr));

    always_comb begin
        statusWord                  = '0;
        statusWord[FifoDepthLog2:0] = fifoCount;
        statusWord[16]              = fifoOverflow;
        statusWord[17]              = fifoEmpty;
    end

    always_comb begin
        dataOut = 32'h0; // Idle bus and unmapped addresses
        if (cs) begin
            if (addr == AddrBits'(decoderPkg::decCtrlAddr)) begin
                dataOut = ctrlRead;
            end else if (addr == AddrBits'(decoderPkg::decStatusAddr)) begin
                dataOut = statusWord;
            end else if (dataHit) begin
                dataOut = {24'h0, fifoData};
            end
        end
    end

    assign pop = cs && rd && dataHit && !fifoEmpty; // Byte shown is the one removed

endmodule

// ==== verilog/decoderTop.sv ====
/*
 * Telemetry decoder front end: control register, bit decoder,
 * byte FIFO and host read port
 */
`timescale 1ns/10ps

module decoderTop #(
    parameter int AddrBits      = 13,
    parameter int FifoDepthLog2 = 4
) (
    input  logic                busClk,
    input  logic                arstN,
    input  logic                cs,
    input  logic                wr0,
    input  logic                wr1,
    input  logic                wr2,
    input  logic                wr3,
    input  logic                rd,
    input  logic [AddrBits-1:0] addr,
    input  logic [31:0]         dataIn,
    input  logic                symA,
    input  logic                symB,
    input  logic                symValid,
    output logic [31:0]         dataOut,
    output logic [1:0]          clkPhase,
    output logic                clkSelect,
    output logic                demuxEnable,
    output logic                feherEnable,
    output logic                iqSwap
);

    decoderPkg::decCtrlWord_u ctrlWord;
    logic [31:0]              ctrlRead;
    logic [7:0]               byteData;
    logic                     byteValid;
    logic [7:0]               fifoData;
    logic [FifoDepthLog2:0]   fifoCount;
    logic                     fifoOverflow;
    logic                     pop;

    // Settings for receiver blocks outside this design
    assign clkPhase    = {ctrlWord.fields.clkPhaseHi, ctrlWord.fields.clkPhaseLo};
    assign clkSelect   = ctrlWord.fields.clkSelect;
    assign demuxEnable = ctrlWord.fields.demuxEnable;
    assign feherEnable = ctrlWord.fields.feherEnable;
    assign iqSwap      = ctrlWord.fields.iqSwap;

    decoderRegs #(.AddrBits(AddrBits)) u_regs (
        .busClk(busClk), .arstN(arstN), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .dataIn(dataIn),
        .ctrlWord(ctrlWord), .ctrlRead(ctrlRead)
    );

    bitDecoder u_bitDecoder (
        .busClk(busClk), .arstN(arstN),
        .symA(symA), .symB(symB), .symValid(symValid),
        .fifoReset(ctrlWord.fields.fifoReset),
        .inputSelect(ctrlWord.fields.inputSelect),
        .dataInvert(ctrlWord.fields.dataInvert),
        .mode(ctrlWord.fields.mode),
        .biphaseEnable(ctrlWord.fields.biphaseEnable),
        .millerEnable(ctrlWord.fields.millerEnable),
        .derandomize({ctrlWord.fields.derandHi, ctrlWord.fields.derandMid,
                      ctrlWord.fields.derandLo}),
        .byteData(byteData), .byteValid(byteValid)
    );

    decoderFifo #(.FifoDepthLog2(FifoDepthLog2)) u_fifo (
        .busClk(busClk), .arstN(arstN),
        .fifoReset(ctrlWord.fields.fifoReset),
        .bypassFifo(ctrlWord.fields.bypassFifo),
        .byteData(byteData), .byteValid(byteValid), .pop(pop),
        .fifoData(fifoData), .fifoCount(fifoCount), .fifoOverflow(fifoOverflow)
    );

    busReadPort #(.AddrBits(AddrBits), .FifoDepthLog2(FifoDepthLog2)) u_readPort (
        .cs(cs), .rd(rd), .addr(addr), .ctrlRead(ctrlRead),
        .fifoData(fifoData), .fifoCount(fifoCount), .fifoOverflow(fifoOverflow),
        .dataOut(dataOut), .pop(pop)
    );

endmodule

// ==== verification/decoderTb.sv ====
/*
 * Testbench for the telemetry decoder front end that drives the host bus and
 * symbol pins and checks control, line codes, derandomizer and FIFO
 */
`timescale 1ns/10ps

module decoderTb;

    localparam int addrBits       = 13;
    localparam int plannedSymbols = (32 + 32 + 32 + 20 + 5) * 16; // Bytes times symbols per byte
    localparam int watchdogCycles = plannedSymbols * 4 + 2000;
    localparam int codeNrzL       = 0;
    localparam int codeNrzM       = 1;
    localparam int codeNrzS       = 2;
    localparam int codeBiphase    = 3;
    localparam int codeMiller     = 4;

    logic                busClk;
    logic                arstN;
    logic                cs;
    logic                wr0;
    logic                wr1;
    logic                wr2;
    logic                wr3;
    logic                rd;
    logic [addrBits-1:0] addr;
    logic [31:0]         dataIn;
    logic                symA;
    logic                symB;
    logic                symValid;
    logic [31:0]         dataOut;
    logic [1:0]          clkPhase;
    logic                clkSelect;
    logic                demuxEnable;
    logic                feherEnable;
    logic                iqSwap;

    logic [31:0] lcgState = 32'd66;
    logic [7:0]  txBytes[$];  // Bytes sent in the current stream
    int          passCount = 0;
    int          failCount = 0;
    int          failMark  = 0;

    decoderTop #(.AddrBits(addrBits), .FifoDepthLog2(4)) u_dut (
        .busClk(busClk), .arstN(arstN), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3), .rd(rd),
        .addr(addr), .dataIn(dataIn),
        .symA(symA), .symB(symB), .symValid(symValid),
        .dataOut(dataOut), .clkPhase(clkPhase), .clkSelect(clkSelect),
        .demuxEnable(demuxEnable), .feherEnable(feherEnable), .iqSwap(iqSwap)
    );

    initial begin
        busClk = 1'b0;
        forever #10 busClk = ~busClk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge busClk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [7:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];
    endfunction

    // Status word as the host should see it
    function automatic logic [31:0] expectStatus(input int count, input logic overflow);
        logic [31:0] word;
        word        = 32'h0;
        word[4:0]   = count[4:0];
        word[16]    = overflow;
        word[17]    = (count == 0);
        return word;
    endfunction

    // Scrambler feedback that inverts the descrambler taps
    function automatic logic scrambleTap(input logic [16:0] hist, input logic [2:0] code);
        if (code == decoderPkg::derandIrig15) begin
            return hist[13] ^ hist[14]; // Delays 14 and 15
        end else if (code == decoderPkg::derandV17) begin
            return hist[13] ^ hist[16]; // Delays 14 and 17
        end
        return 1'b0;
    endfunction

    task automatic applyLanes(inout decoderPkg::decCtrlWord_u word, input logic [31:0] data,
                              input logic [3:0] lanes);
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                word.raw[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        word.fields.unused = '0;
    endtask

    task automatic busWrite(input int address, input logic [31:0] data, input logic [3:0] lanes);
        @(negedge busClk);
        cs     = 1'b1;
        addr   = addrBits'(address);
        dataIn = data;
        {wr3, wr2, wr1, wr0} = lanes;
        @(negedge busClk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0;
    endtask

    task automatic busRead(input int address, output logic [31:0] data);
        @(negedge busClk);
        cs   = 1'b1;
        rd   = 1'b1;
        addr = addrBits'(address);
        #1 data = dataOut; // Settled well before the popping edge
        @(negedge busClk);
        cs = 1'b0;
        rd = 1'b0;
    endtask

    task automatic recordCheck(input logic ok, input string name, input logic [31:0] expV,
                               input logic [31:0] actV);
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
            $display("CHECK FAILED %s: expected %h, got %h", name, expV, actV);
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expV, input logic [7:0] actV);
        recordCheck(expV === actV, name, {24'h0, expV}, {24'h0, actV});
    endtask

    task automatic checkStatus(input string name, input logic [31:0] expV,
                               input logic [31:0] actV);
        recordCheck(expV === actV, name, expV, actV);
    endtask

    task automatic showField(input string name, input logic [14:0] expV, input logic [14:0] actV);
        if (expV !== actV) begin
            $display("  field %s: expected %h, got %h", name, expV, actV);
        end
    endtask

    task automatic checkCtrl(input decoderPkg::decCtrlWord_u expW,
                             input decoderPkg::decCtrlWord_u actW);
        recordCheck(expW.raw === actW.raw, "ctrlWord", expW.raw, actW.raw);
        if (expW.raw !== actW.raw) begin
            showField("unused", expW.fields.unused, actW.fields.unused);
            showField("clkPhaseHi", 15'(expW.fields.clkPhaseHi), 15'(actW.fields.clkPhaseHi));
            showField("derandHi", 15'(expW.fields.derandHi), 15'(actW.fields.derandHi));
            showField("inputSelect", 15'(expW.fields.inputSelect), 15'(actW.fields.inputSelect));
            showField("bypassFifo", 15'(expW.fields.bypassFifo), 15'(actW.fields.bypassFifo));
            showField("derandMid", 15'(expW.fields.derandMid), 15'(actW.fields.derandMid));
            showField("mode", 15'(expW.fields.mode), 15'(actW.fields.mode));
            showField("millerEnable", 15'(expW.fields.millerEnable),
                      15'(actW.fields.millerEnable));
            showField("biphaseEnable", 15'(expW.fields.biphaseEnable),
                      15'(actW.fields.biphaseEnable));
            showField("iqSwap", 15'(expW.fields.iqSwap), 15'(actW.fields.iqSwap));
            showField("feherEnable", 15'(expW.fields.feherEnable), 15'(actW.fields.feherEnable));
            showField("demuxEnable", 15'(expW.fields.demuxEnable), 15'(actW.fields.demuxEnable));
            showField("derandLo", 15'(expW.fields.derandLo), 15'(actW.fields.derandLo));
            showField("dataInvert", 15'(expW.fields.dataInvert), 15'(actW.fields.dataInvert));
            showField("clkSelect", 15'(expW.fields.clkSelect), 15'(actW.fields.clkSelect));
            showField("clkPhaseLo", 15'(expW.fields.clkPhaseLo), 15'(actW.fields.clkPhaseLo));
            showField("fifoReset", 15'(expW.fields.fifoReset), 15'(actW.fields.fifoReset));
        end
    endtask

    // Receiver settings leaving the top level
    task automatic checkPassThrough(input decoderPkg::decCtrlWord_u expW);
        checkByte("passThrough",
                  {2'b0, expW.fields.clkPhaseHi, expW.fields.clkPhaseLo, expW.fields.clkSelect,
                   expW.fields.demuxEnable, expW.fields.feherEnable, expW.fields.iqSwap},
                  {2'b0, clkPhase, clkSelect, demuxEnable, feherEnable, iqSwap});
    endtask

    task automatic finishTest(input string name);
        if (failCount == failMark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d failed checks", name, failCount - failMark);
        end
        failMark = failCount;
    endtask

    // Write the settings with fifoReset pulsed to clear FIFO and decoder state
    task automatic configure(input decoderPkg::decCtrlWord_u cfg);
        cfg.fields.fifoReset = 1'b1;
        busWrite(decoderPkg::decCtrlAddr, cfg.raw, 4'hF);
        cfg.fields.fifoReset = 1'b0;
        busWrite(decoderPkg::decCtrlAddr, cfg.raw, 4'hF);
    endtask

    task automatic driveSymbol(input logic sym, input logic useB);
        @(negedge busClk);
        symValid = 1'b1;
        symA     = useB ? ~sym : sym; // Idle input carries the opposite level
        symB     = useB ? sym : ~sym;
        @(negedge busClk);
        symValid = 1'b0;
    endtask

    task automatic sendBits(input int lineCode, input logic useB, input logic invert,
                            input logic [2:0] derand);
        logic [16:0] hist;
        logic        level;
        logic        txBit;
        logic        firstSym;
        logic        secondSym;
        int          b;
        hist  = '0;
        level = 1'b0;
        foreach (txBytes[i]) begin
            for (b = 7; b >= 0; b--) begin
                txBit = txBytes[i][b] ^ scrambleTap(hist, derand);
                hist  = {hist[15:0], txBit};
                case (lineCode)
                    codeBiphase: begin
                        firstSym  = txBit;
                        secondSym = ~txBit;
                    end
                    codeMiller: begin
                        firstSym  = level;
                        secondSym = level ^ txBit; // Mid-bit change for a one
                        level     = secondSym;
                    end
                    codeNrzM: begin
                        level     = level ^ txBit;
                        firstSym  = level;
                        secondSym = level;
                    end
                    codeNrzS: begin
                        level     = level ^ ~txBit;
                        firstSym  = level;
                        secondSym = level;
                    end
                    default: begin
                        firstSym  = txBit;
                        secondSym = txBit;
                    end
                endcase
                driveSymbol(firstSym ^ invert, useB);
                driveSymbol(secondSym ^ invert, useB);
            end
        end
        repeat (3) @(negedge busClk);
    endtask

    task automatic waitCount(input int target);
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            busRead(decoderPkg::decStatusAddr, status);
            polls++;
        end while ((int'(status[4:0]) < target) && (polls < 50));
        if (int'(status[4:0]) < target) begin
            failCount++;
            $display("FIFO count stayed at %0d while waiting for %0d bytes", status[4:0], target);
        end
    endtask

    task automatic readExpected(input int count, input int skip);
        logic [31:0] data;
        for (int i = 0; i < count; i++) begin
            waitCount(1);
            busRead(decoderPkg::decFifoDataAddr, data);
            if (i >= skip) begin
                checkByte("fifoData", txBytes[i], data[7:0]);
            end
        end
    endtask

    task automatic runStream(input decoderPkg::decCtrlWord_u cfg, input int count,
                             input int lineCode, input logic useB, input logic invert,
                             input logic [2:0] derand, input int skip);
        logic [31:0] status;
        {cfg.fields.derandHi, cfg.fields.derandMid, cfg.fields.derandLo} = derand;
        configure(cfg);
        txBytes.delete();
        repeat (count) txBytes.push_back(nextRand());
        sendBits(lineCode, useB, invert, derand);
        readExpected(count, skip);
        busRead(decoderPkg::decStatusAddr, status);
        checkStatus("status", expectStatus(0, 1'b0), status);
    endtask

    task automatic testByteLanes();
        decoderPkg::decCtrlWord_u expW;
        decoderPkg::decCtrlWord_u actW;
        logic [31:0]              data;
        expW.raw = '0;
        busWrite(decoderPkg::decCtrlAddr, 32'h0, 4'hF);
        busWrite(decoderPkg::decCtrlAddr, 32'hFFFF_FFFF, 4'b0010);
        applyLanes(expW, 32'hFFFF_FFFF, 4'b0010);
        busRead(decoderPkg::decCtrlAddr, data);
        actW.raw = data;
        checkCtrl(expW, actW);
        busWrite(decoderPkg::decCtrlAddr, 32'h5AC3_3CA5, 4'b1101);
        applyLanes(expW, 32'h5AC3_3CA5, 4'b1101);
        busRead(decoderPkg::decCtrlAddr, data);
        actW.raw = data;
        checkCtrl(expW, actW);
        checkPassThrough(expW);
        busWrite(decoderPkg::decCtrlAddr, 32'h003C_005A, 4'b0101); // Flip the receiver settings
        applyLanes(expW, 32'h003C_005A, 4'b0101);
        busRead(decoderPkg::decCtrlAddr, data);
        actW.raw = data;
        checkCtrl(expW, actW);
        checkPassThrough(expW);
        busWrite(decoderPkg::decCtrlAddr, 32'h0, 4'hF);
        finishTest("byte lanes");
    endtask

    task automatic testNrzL();
        decoderPkg::decCtrlWord_u cfg;
        cfg.raw = '0;
        runStream(cfg, 16, codeNrzL, 1'b0, 1'b0, decoderPkg::derandOff, 0);
        cfg.fields.inputSelect = 1'b1;
        cfg.fields.dataInvert  = 1'b1;
        runStream(cfg, 16, codeNrzL, 1'b1, 1'b1, decoderPkg::derandOff, 0);
        finishTest("NRZ-L");
    endtask

    task automatic testLineCodes();
        decoderPkg::decCtrlWord_u cfg;
        cfg.raw = '0;
        cfg.fields.biphaseEnable = 1'b1;
        cfg.fields.mode          = decoderPkg::nrzS; // Biphase wins over the NRZ mode
        runStream(cfg, 8, codeBiphase, 1'b0, 1'b0, decoderPkg::derandOff, 0);
        cfg.raw = '0;
        cfg.fields.millerEnable  = 1'b1;
        cfg.fields.biphaseEnable = 1'b1; // Miller wins over biphase
        runStream(cfg, 8, codeMiller, 1'b0, 1'b0, decoderPkg::derandOff, 0);
        cfg.raw = '0;
        cfg.fields.mode = decoderPkg::nrzM;
        runStream(cfg, 8, codeNrzM, 1'b0, 1'b0, decoderPkg::derandOff, 0);
        cfg.fields.mode = decoderPkg::nrzS;
        runStream(cfg, 8, codeNrzS, 1'b0, 1'b0, decoderPkg::derandOff, 0);
        finishTest("line codes");
    endtask

    task automatic testDerandomizer();
        decoderPkg::decCtrlWord_u cfg;
        cfg.raw = '0;
        runStream(cfg, 16, codeNrzL, 1'b0, 1'b0, decoderPkg::derandIrig15, 2);
        runStream(cfg, 16, codeNrzL, 1'b0, 1'b0, decoderPkg::derandV17, 2);
        finishTest("derandomizer");
    endtask

    task automatic testFifoLimits();
        decoderPkg::decCtrlWord_u cfg;
        logic [31:0]              status;
        cfg.raw = '0;
        configure(cfg);
        txBytes.delete();
        repeat (20) txBytes.push_back(nextRand());
        sendBits(codeNrzL, 1'b0, 1'b0, decoderPkg::derandOff);
        waitCount(16);
        busRead(decoderPkg::decStatusAddr, status);
        checkStatus("status", expectStatus(16, 1'b1), status);
        readExpected(16, 0);
        configure(cfg);
        busRead(decoderPkg::decStatusAddr, status);
        checkStatus("status", expectStatus(0, 1'b0), status);
        finishTest("FIFO limits");
    endtask

    task automatic testBypass();
        decoderPkg::decCtrlWord_u cfg;
        logic [31:0]              data;
        cfg.raw = '0;
        cfg.fields.bypassFifo = 1'b1;
        configure(cfg);
        txBytes.delete();
        repeat (5) txBytes.push_back(nextRand());
        sendBits(codeNrzL, 1'b0, 1'b0, decoderPkg::derandOff);
        waitCount(1);
        busRead(decoderPkg::decStatusAddr, data);
        checkStatus("status", expectStatus(1, 1'b0), data);
        busRead(decoderPkg::decFifoDataAddr, data);
        checkByte("fifoData", txBytes[4], data[7:0]); // Newest byte only
        busRead(decoderPkg::decStatusAddr, data);
        checkStatus("status", expectStatus(0, 1'b0), data);
        finishTest("bypass");
    endtask

    initial begin
        arstN    = 1'b0;
        cs       = 1'b0;
        wr0      = 1'b0;
        wr1      = 1'b0;
        wr2      = 1'b0;
        wr3      = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        dataIn   = 32'h0;
        symA     = 1'b0;
        symB     = 1'b0;
        symValid = 1'b0;
        repeat (10) @(negedge busClk);
        arstN = 1'b1;
        testByteLanes();
        testNrzL();
        testLineCodes();
        testDerandomizer();
        testFifoLimits();
        testBypass();
        $display("Summary: %0d checks passed, %0d checks failed", passCount, failCount);
        if (failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/decoderPkg.sv
verilog/decoderRegs.sv
verilog/bitDecoder.sv
verilog/decoderFifo.sv
verilog/busReadPort.sv
verilog/decoderTop.sv
verification/decoderTb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := decoderTb
FILELIST := tb.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -F -q '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
